// File: logic/hackPkg.sv
// Shared types and constants for the HACK system on chip
// Memory map keeps only RAM, LED, button, UART TX and one debug register
// Addresses are 15 bits wide as seen on the CPU data bus
package hackPkg;

	typedef logic [15:0] hackWord; // Data and instruction word

	localparam int romDepth = 256; // ROM indexed by pc[7:0]
	localparam int ramWords = 3840; // Addresses 0 to 3839
	localparam logic [14:0] addrLed = 15'd4096;
	localparam logic [14:0] addrBut = 15'd4097;
	localparam logic [14:0] addrUart = 15'd4098; // Read busy in bit 15, write sends byte
	localparam logic [14:0] addrDebug = 15'd4107;
	localparam int clocksPerBit = 8; // UART bit time in clocks

	// zx nx zy ny f no
	typedef enum logic [5:0] {
		aluZero = 6'b101010,
		aluOne = 6'b111111,
		aluD = 6'b001100,
		aluA = 6'b110000,
		aluNotD = 6'b001101,
		aluAddDA = 6'b000010,
		aluSubDA = 6'b010011,
		aluAndDA = 6'b000000,
		aluOrDA = 6'b010101,
		aluIncA = 6'b110111
	} aluOp;

	// Bits are lt, eq, gt
	typedef enum logic [2:0] {
		jmpNone, jmpGt, jmpEq, jmpGe, jmpLt, jmpNe, jmpLe, jmpAlways
	} jumpCond;

endpackage

// File: logic/memBus.sv
// CPU data memory bus, one access per cycle, no handshake
// writeM high means the addressed location loads outM at the next edge
// inM is combinational from address in the same cycle
interface memBus;
	import hackPkg::*;

	logic [14:0] address; // Always the A register
	hackWord outM; // ALU result
	logic writeM;
	hackWord inM; // Read data from the memory map

	modport cpu (
		output address, outM, writeM,
		input inM
	);

	modport map (
		input address, outM, writeM,
		output inM
	);

endinterface

// File: logic/hackAlu.sv
// HACK ALU, purely combinational
// Control bits in order zx nx zy ny f no, any 6-bit code is accepted
module hackAlu (
	input hackPkg::hackWord x,
	input hackPkg::hackWord y,
	input logic [5:0] control,
	output hackPkg::hackWord result,
	output logic zero,
	output logic negative
);
	import hackPkg::*;

	hackWord xZ, xN; // x after zero, after invert
	hackWord yZ, yN;
	hackWord fOut; // Sum or AND

	assign xZ = control[5] ? '0 : x; // zx
	assign xN = control[4] ? ~xZ : xZ; // nx
	assign yZ = control[3] ? '0 : y; // zy
	assign yN = control[2] ? ~yZ : yZ; // ny
	assign fOut = control[1] ? (xN + yN) : (xN & yN); // f selects add
	assign result = control[0] ? ~fOut : fOut; // no

	assign zero = (result == '0);
	assign negative = result[15]; // Two's complement sign

endmodule

// File: logic/hackCpu.sv
// HACK CPU with A, D and PC registers
// One instruction per clock, writes land at the edge ending the cycle
// PC is 15 bits, only the low bits reach the ROM
// writeM is decoded straight from the instruction word
module hackCpu (
	input logic clk,
	input logic reset,
	input hackPkg::hackWord instruction,
	output logic [14:0] pc,
	memBus.cpu bus
);
	import hackPkg::*;

	hackWord aReg, dReg;
	hackWord aluY, aluOut;
	logic aluZ, aluN;
	logic isC; // C-instruction flag
	logic loadA, loadD;
	logic takeJump;

	assign isC = instruction[15];
	assign loadA = !isC || instruction[5]; // A-instruction or dest A
	assign loadD = isC && instruction[4];
	assign aluY = instruction[12] ? bus.inM : aReg; // a bit picks M

	hackAlu alu_i (
		.x(dReg),
		.y(aluY),
		.control(instruction[11:6]),
		.result(aluOut),
		.zero(aluZ),
		.negative(aluN)
	);

	always_comb begin
		unique case (jumpCond'(instruction[2:0]))
			jmpNone: takeJump = 1'b0;
			jmpGt: takeJump = !aluZ && !aluN;
			jmpEq: takeJump = aluZ;
			jmpGe: takeJump = !aluN;
			jmpLt: takeJump = aluN;
			jmpNe: takeJump = !aluZ;
			jmpLe: takeJump = aluZ || aluN;
			jmpAlways: takeJump = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			aReg <= '0;
			dReg <= '0;
			pc <= '0;
		end else begin
			if (loadA)
				aReg <= isC ? aluOut : {1'b0, instruction[14:0]}; // Constant has MSB 0
			if (loadD)
				dReg <= aluOut;
			if (isC && takeJump)
				pc <= aReg[14:0]; // Jump target is old A
			else
				pc <= pc + 15'd1;
		end
	end

	assign bus.address = aReg[14:0];
	assign bus.outM = aluOut;
	assign bus.writeM = isC && instruction[3]; // dest M

	// Execution restarts at address 0
	assert property (@(posedge clk) reset |=> pc == '0)
		else $error("PC not 0 after reset");

endmodule

// File: logic/memoryMap.sv
// Decodes CPU addresses into RAM and I/O loads and muxes read data
// Below 3840 is RAM, then LED 4096, button 4097, UART 4098, debug 4107
// Unmapped addresses read 0 and ignore writes, button writes are dropped
// Button is sampled once, reads lag the pins by one cycle
module memoryMap (
	input logic clk,
	input logic reset,
	memBus.map bus,
	output logic ramLoad,
	input hackPkg::hackWord ramOut,
	output logic uartLoad,
	input logic uartBusy,
	input logic [1:0] but,
	output logic [1:0] led
);
	import hackPkg::*;

	hackWord ledReg, debugReg;
	logic [1:0] butReg;
	logic isRam;
	logic ledLoad, debugLoad;

	assign isRam = bus.address < 15'(ramWords);
	assign ramLoad = bus.writeM && isRam;
	assign ledLoad = bus.writeM && (bus.address == addrLed);
	assign uartLoad = bus.writeM && (bus.address == addrUart);
	assign debugLoad = bus.writeM && (bus.address == addrDebug);

	always_ff @(posedge clk) begin
		if (reset) begin
			ledReg <= '0;
			debugReg <= '0;
		end else begin
			if (ledLoad)
				ledReg <= bus.outM;
			if (debugLoad)
				debugReg <= bus.outM;
		end
	end

	always_ff @(posedge clk)
		butReg <= but; // Single sampling stage

	always_comb begin
		if (isRam)
			bus.inM = ramOut;
		else case (bus.address)
			addrLed: bus.inM = ledReg; // Full word reads back
			addrBut: bus.inM = {14'd0, butReg};
			addrUart: bus.inM = {uartBusy, 15'd0}; // Busy in bit 15
			addrDebug: bus.inM = debugReg;
			default: bus.inM = '0;
		endcase
	end

	assign led = ledReg[1:0];

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({ramLoad, ledLoad, uartLoad, debugLoad}))
		else $error("More than one load strobe active");

endmodule

// File: logic/programRom.sv
// Instruction store, 256 words, asynchronous read
// Load port writes one word per edge, top gates it with reset
module programRom (
	input logic clk,
	input logic [7:0] address,
	output hackPkg::hackWord instruction,
	input logic progWrite,
	input logic [7:0] progAddr,
	input hackPkg::hackWord progData
);
	import hackPkg::*;

	hackWord mem [romDepth];

	always_ff @(posedge clk) begin
		if (progWrite)
			mem[progAddr] <= progData; // Boot loader or bench path
	end

	assign instruction = mem[address];

endmodule

// File: logic/dataRam.sv
// Data RAM, 3840 words, write at the rising edge, read asynchronous
// Contents are undefined until written
// Addresses 3840 to 4095 are outside the array, the memory map never loads them
module dataRam (
	input logic clk,
	input logic [11:0] address,
	input hackPkg::hackWord in,
	input logic load,
	output hackPkg::hackWord out
);
	import hackPkg::*;

	hackWord mem [ramWords];

	always_ff @(posedge clk) begin
		if (load)
			mem[address] <= in;
	end

	assign out = mem[address]; // Only used below 3840

	// Decode upstream must keep I/O writes out of the array
	assert property (@(posedge clk) load |-> address < 12'(ramWords))
		else $error("RAM load at address %0d", address);

endmodule

// File: logic/uartTx.sv
// 8N1 serial transmitter, LSB first, clocksPerBit clocks per bit
// Load while idle starts the start bit on the next cycle
// Load while busy is dropped, busy lasts 10 bit times
module uartTx #(
	parameter int clocksPerBit = hackPkg::clocksPerBit
) (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [7:0] data,
	output logic busy,
	output logic txd
);
	localparam int timerBits = $clog2(clocksPerBit + 1);

	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState;

	txState state;
	logic [timerBits-1:0] bitTimer;
	logic [2:0] bitIndex;
	logic [7:0] shiftReg;
	logic bitDone;

	assign bitDone = bitTimer == timerBits'(clocksPerBit - 1);
	assign busy = state != txIdle;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= txIdle;
			txd <= 1'b1; // Line idles high
			bitTimer <= '0;
			bitIndex <= '0;
		end else begin
			bitTimer <= (state == txIdle || bitDone) ? '0 : bitTimer + 1'b1;
			case (state)
				txIdle: if (load) begin
					state <= txStart;
					txd <= 1'b0; // Start bit
					shiftReg <= data;
				end
				txStart: if (bitDone) begin
					state <= txData;
					txd <= shiftReg[0];
					shiftReg <= shiftReg >> 1;
					bitIndex <= '0;
				end
				txData: if (bitDone) begin
					if (bitIndex == 3'd7) begin
						state <= txStop;
						txd <= 1'b1; // Stop bit
					end else begin
						bitIndex <= bitIndex + 3'd1;
						txd <= shiftReg[0];
						shiftReg <= shiftReg >> 1;
					end
				end
				txStop: if (bitDone)
					state <= txIdle;
				default: state <= txIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) state == txIdle |-> txd)
		else $error("txd low while idle");

endmodule

// File: logic/hackTop.sv
// HACK system top, single clock, synchronous active-high reset
// Programs are written through progWrite only while reset is high
// led shows the low 2 bits of the LED register, uartTxd is 8N1
module hackTop (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [7:0] progAddr,
	input hackPkg::hackWord progData,
	input logic [1:0] but,
	output logic [1:0] led,
	output logic uartTxd
);
	logic [14:0] pc;
	hackPkg::hackWord instruction;
	hackPkg::hackWord ramOut;
	logic ramLoad, uartLoad, uartBusy;

	memBus bus ();

	hackCpu cpu_i (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.pc(pc),
		.bus(bus.cpu)
	);

	programRom rom_i (
		.clk(clk),
		.address(pc[7:0]), // 256 words, upper PC bits wrap
		.instruction(instruction),
		.progWrite(progWrite && reset), // Loader only while CPU is held
		.progAddr(progAddr),
		.progData(progData)
	);

	memoryMap map_i (
		.clk(clk),
		.reset(reset),
		.bus(bus.map),
		.ramLoad(ramLoad),
		.ramOut(ramOut),
		.uartLoad(uartLoad),
		.uartBusy(uartBusy),
		.but(but),
		.led(led)
	);

	dataRam ram_i (
		.clk(clk),
		.address(bus.address[11:0]),
		.in(bus.outM),
		.load(ramLoad),
		.out(ramOut)
	);

	uartTx uart_i (
		.clk(clk),
		.reset(reset),
		.load(uartLoad),
		.data(bus.outM[7:0]), // Low byte is sent
		.busy(uartBusy),
		.txd(uartTxd)
	);

endmodule

// File: bench/hackPrograms.svh
// Test programs for the HACK testbench, each loaded at ROM address 0
// Every program ends in a two-word halt loop and writes the LED once at most
// Expected LED and UART values are worked out by hand from the HACK rules
localparam int numTests = 7;

typedef struct packed {
	logic [7:0] start, len; // Slice of progWords
	logic [1:0] but, led; // Button drive, expected LED
	logic hasUart; // Run ends on a UART frame
	logic [7:0] uartByte;
	logic [15:0] budget; // Cycles allowed after reset
} testEntry;

localparam hackWord progWords [89] = '{
	16'h000D, 16'hEC10, 16'h0006, 16'hE090, 16'h0005, 16'hE4D0, 16'h0007, 16'hE010, // ALU
	16'hE350, 16'h1000, 16'hE308, 16'h000B, 16'hEA87,
	16'h0003, 16'hEC10, 16'h0000, 16'hEA88, 16'h0000, 16'hFDC8, 16'hE390, 16'h0004, // JGT
	16'hE301, 16'h0000, 16'hFC10, 16'h1000, 16'hE308, 16'h000D, 16'hEA87,
	16'h0002, 16'hEC10, 16'h0000, 16'hEA88, 16'h000B, 16'hE302, 16'h0000, 16'hFDC8, // JEQ
	16'hE390, 16'h0004, 16'hEA87, 16'h0000, 16'hFC10, 16'h1000, 16'hE308, 16'h000F,
	16'hEA87,
	16'h0005, 16'hEC10, 16'h0000, 16'hE308, 16'h0009, 16'hEC10, 16'h0064, 16'hE308, // RAM
	16'h0011, 16'hEC10, 16'h0EFF, 16'hE308, 16'h0000, 16'hFC10, 16'h0064, 16'hF090,
	16'h0EFF, 16'hF090, 16'h1000, 16'hE308, 16'h0014, 16'hEA87,
	16'h1001, 16'hFC10, 16'h100B, 16'hE308, 16'h1388, 16'hFC10, 16'h100B, 16'hF090, // Button
	16'h1000, 16'hE308, 16'h000A, 16'hEA87,
	16'h1002, 16'hFC10, 16'h0000, 16'hE304, 16'h00A5, 16'hEC10, 16'h1002, 16'hE308, // UART
	16'h0008, 16'hEA87
};

localparam testEntry tests [numTests] = '{
	'{8'd0, 8'd13, 2'd0, 2'd1, 1'b0, 8'h00, 16'd40}, // !((13+6-5)&7) ends in 01
	'{8'd13, 8'd15, 2'd0, 2'd3, 1'b0, 8'h00, 16'd60}, // JGT countdown from 3
	'{8'd28, 8'd17, 2'd0, 2'd2, 1'b0, 8'h00, 16'd60}, // JEQ exit after 2 passes
	'{8'd45, 8'd22, 2'd0, 2'd3, 1'b0, 8'h00, 16'd50}, // 5+9+17 at 0, 100, 3839
	'{8'd67, 8'd12, 2'd2, 2'd2, 1'b0, 8'h00, 16'd40}, // Button via 4107 plus 5000
	'{8'd67, 8'd12, 2'd1, 2'd1, 1'b0, 8'h00, 16'd40},
	'{8'd79, 8'd10, 2'd0, 2'd0, 1'b1, 8'hA5, 16'd40} // Poll busy, send A5
};

// File: bench/hackTb.sv
// HACK system testbench, every table program runs from a fresh reset
// A run ends when the LED leaves 0 or the UART start bit appears
// The first mismatch or timeout stops the simulation
module hackTb;
	import hackPkg::*;

	`include "hackPrograms.svh"

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic progWrite = 1'b0;
	logic [7:0] progAddr = '0;
	hackWord progData = '0;
	logic [1:0] but = '0;
	logic [1:0] led;
	logic uartTxd;
	logic [7:0] rxByte; // Decoded UART frame
	testEntry t;
	int cycles;

	hackTop dut_i (.clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
		.progData(progData), .but(but), .led(led), .uartTxd(uartTxd));

	always #50 clk = ~clk; // Period 100

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abortRun($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	// CPU held in reset 4 cycles, then one ROM word per cycle
	task automatic loadProgram(input testEntry e);
		@(posedge clk);
		reset <= 1'b1;
		but <= e.but; // Sampled by the map every cycle
		repeat (4) @(posedge clk);
		for (int i = 0; i < e.len; i++) begin
			progWrite <= 1'b1;
			progAddr <= 8'(i);
			progData <= progWords[e.start + i];
			@(posedge clk);
		end
		progWrite <= 1'b0;
		reset <= 1'b0; // Last word stored at this edge
	endtask

	initial begin
		for (int n = 0; n < numTests; n++) begin
			t = tests[n];
			loadProgram(t);
			cycles = 0;
			@(negedge clk); // Outputs settled
			// Single LED write per program, first change is the result
			while ((t.hasUart ? uartTxd !== 1'b0 : led === 2'd0) && cycles < t.budget) begin
				@(negedge clk);
				cycles++;
			end
			if (t.hasUart ? uartTxd !== 1'b0 : led === 2'd0)
				abortRun($sformatf("Timeout in test %0d waiting for %s", n,
					t.hasUart ? "the UART start bit" : "the LED to change"));
			else begin
				if (t.hasUart) begin
					// First low sample lies half a cycle into the start bit
					repeat (clocksPerBit / 2) @(negedge clk);
					checkValue("uartTxd start bit", uartTxd, 1'b0);
					for (int b = 0; b < 8; b++) begin
						repeat (clocksPerBit) @(negedge clk); // Mid-bit
						rxByte[b] = uartTxd; // LSB first
					end
					repeat (clocksPerBit) @(negedge clk);
					checkValue("uartTxd stop bit", uartTxd, 1'b1);
					checkValue("uart byte", rxByte, t.uartByte);
				end
				checkValue("led", led, t.led);
			end
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// File: hackSoc.f
+incdir+bench
logic/hackPkg.sv
logic/memBus.sv
logic/hackAlu.sv
logic/hackCpu.sv
logic/memoryMap.sv
logic/programRom.sv
logic/dataRam.sv
logic/uartTx.sv
logic/hackTop.sv
bench/hackTb.sv

// File: Bender.yml
package:
  name: hackSoc

sources:
  - logic/hackPkg.sv
  - logic/memBus.sv
  - logic/hackAlu.sv
  - logic/hackCpu.sv
  - logic/memoryMap.sv
  - logic/programRom.sv
  - logic/dataRam.sv
  - logic/uartTx.sv
  - logic/hackTop.sv
  - include_dirs:
      - bench
    files:
      - bench/hackTb.sv
